// File: test/calc_ctrl_stimulus.txt
# cmd mode m n id op exp_a exp_b exp_total exp_types exp_led(hex)
# store/errflag: exp_a base; calc: exp_a op1 addr, exp_b result addr; retry: first and second base
store   0 2 3 0 0  0  0 1 1 02
store   1 2 3 0 0  6  0 2 1 04
store   0 2 3 0 0  0  0 2 1 02
store   0 1 4 0 0 12  0 3 2 02
calc    2 2 3 2 0  6 20 4 3 80
badid   2 2 3 3 0  0  0 4 3 ff
nohit   2 5 5 1 0  0  0 4 3 ff
retry   1 1 4 0 0 16 12 5 3 04
errflag 0 3 2 0 0 26  0 6 3 ff
calc    2 1 4 1 0 12 32 7 4 80

// File: tb.f
+incdir+source
source/calc_ctrl_pkg.sv
source/mode_sequencer.sv
source/operand_select.sv
source/type_ledger.sv
source/calc_ctrl_top.sv
test/tb_calc_ctrl.sv

// File: test/tb_calc_ctrl.sv
`timescale 1ns/1ps
`include "calc_ctrl_cfg.svh"

module tb_calc_ctrl;
    import calc_ctrl_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_TESTS  = 32;
    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   rst_n;
    logic [1:0]             i_btn;
    logic [1:0]             i_mode_sel;
    op_code_t               i_op_sel;
    logic                   i_dims_valid;
    dim_t                   i_dim_m;
    dim_t                   i_dim_n;
    logic                   i_rx_done;
    logic                   i_error_flag;
    logic [1:0]             i_id_val;
    logic                   i_id_valid;
    logic                   i_calc_done;
    logic                   o_en_input;
    logic                   o_is_gen_mode;
    logic [1:0]             o_task_mode;
    logic                   o_addr_ready;
    addr_t                  o_base_addr;
    logic                   o_start_calc;
    op_code_t               o_op_code;
    addr_t                  o_op1_addr;
    dim_t                   o_op1_m;
    dim_t                   o_op1_n;
    addr_t                  o_op2_addr;
    dim_t                   o_op2_m;
    dim_t                   o_op2_n;
    addr_t                  o_res_addr;
    logic [7:0]             o_led;
    ctrl_state_t            o_state;
    logic [`CC_TOTAL_W-1:0] o_total_count;
    logic [`CC_TYPES_W-1:0] o_types_count;

    // one row per test from the stimulus file
    reg [63:0] t_cmd   [MAX_TESTS];
    int        t_mode  [MAX_TESTS];
    int        t_m     [MAX_TESTS];
    int        t_n     [MAX_TESTS];
    int        t_id    [MAX_TESTS];
    int        t_op    [MAX_TESTS];
    int        t_a     [MAX_TESTS];
    int        t_b     [MAX_TESTS];
    int        t_total [MAX_TESTS];
    int        t_types [MAX_TESTS];
    int        t_led   [MAX_TESTS];

    int   n_tests;
    int   cur;
    int   errors;
    int   tests_failed;
    int   seed_dummy;
    logic loaded;

    calc_ctrl_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_btn         (i_btn),
        .i_mode_sel    (i_mode_sel),
        .i_op_sel      (i_op_sel),
        .i_dims_valid  (i_dims_valid),
        .i_dim_m       (i_dim_m),
        .i_dim_n       (i_dim_n),
        .i_rx_done     (i_rx_done),
        .i_error_flag  (i_error_flag),
        .i_id_val      (i_id_val),
        .i_id_valid    (i_id_valid),
        .o_en_input    (o_en_input),
        .o_is_gen_mode (o_is_gen_mode),
        .o_task_mode   (o_task_mode),
        .o_addr_ready  (o_addr_ready),
        .o_base_addr   (o_base_addr),
        .i_calc_done   (i_calc_done),
        .o_start_calc  (o_start_calc),
        .o_op_code     (o_op_code),
        .o_op1_addr    (o_op1_addr),
        .o_op1_m       (o_op1_m),
        .o_op1_n       (o_op1_n),
        .o_op2_addr    (o_op2_addr),
        .o_op2_m       (o_op2_m),
        .o_op2_n       (o_op2_n),
        .o_res_addr    (o_res_addr),
        .o_led         (o_led),
        .o_state       (o_state),
        .o_total_count (o_total_count),
        .o_types_count (o_types_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // helpers
    // ==============================
    // drive phase just after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic gap();
        int n;
        n = $urandom % 4 + 1;
        repeat (n) step();
    endtask

    task automatic mismatch(input string what, input int exp_v, input int act_v);
        $display("** Error %0s_%0d %0s: expected %0d, actual %0d",
                 t_cmd[cur], cur, what, exp_v, act_v);
        errors++;
    endtask

    task automatic fault(input string what);
        $display("test %0d (%0s): %0s", cur, t_cmd[cur], what);
        errors++;
    endtask

    // returns on a falling edge once the state is reached
    task automatic wait_state(input ctrl_state_t st);
        int n;
        n = 0;
        @(negedge clk);
        while (o_state != st && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (o_state != st) begin
            fault($sformatf("timed out waiting for state %0d", st));
        end
    endtask

    task automatic wait_addr_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (o_addr_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (o_addr_ready !== 1'b1) begin
            fault("address ready never rose");
        end
    endtask

    task automatic press(input int idx);
        step();
        i_btn[idx] = 1'b1;
        repeat (3) step();
        i_btn[idx] = 1'b0;
    endtask

    task automatic enter_mode(input int mode);
        step();
        i_mode_sel = mode[1:0];
        press(0);
        wait_state((mode == 2) ? CALC_SELECT_OP : STORE);
    endtask

    task automatic go_idle();
        press(0);
        wait_state(IDLE);
        @(negedge clk);
        if (o_led !== `CC_LED_IDLE) mismatch("idle led", `CC_LED_IDLE, o_led);
    endtask

    task automatic check_counts();
        if (o_total_count !== t_total[cur]) mismatch("total count", t_total[cur], o_total_count);
        if (o_types_count !== t_types[cur]) mismatch("types count", t_types[cur], o_types_count);
    endtask

    // ==============================
    // input subsystem
    // ==============================
    task automatic do_store(input int m, input int n, input logic flag,
                            output int base_seen, output int led_seen);
        step();
        i_dim_m      = dim_t'(m);
        i_dim_n      = dim_t'(n);
        i_dims_valid = 1'b1;
        i_error_flag = flag;
        wait_addr_ready();
        base_seen = o_base_addr;
        led_seen  = o_led;
        if (o_en_input !== 1'b1) fault("input enable low during store");
        step();
        i_dims_valid = 1'b0;
        i_error_flag = 1'b0;
        gap();
        i_rx_done = 1'b1;
        step();
        i_rx_done = 1'b0;
        wait_state(WAIT_DECISION);
    endtask

    task automatic run_store(input logic flag);
        int base;
        int led;
        enter_mode(t_mode[cur]);
        do_store(t_m[cur], t_n[cur], flag, base, led);
        if (base !== t_a[cur]) mismatch("base address", t_a[cur], base);
        if (led !== t_led[cur]) mismatch("store led", t_led[cur], led);
        check_counts();
        go_idle();
    endtask

    task automatic run_retry();
        int base;
        int led;
        enter_mode(t_mode[cur]);
        do_store(t_m[cur], t_n[cur], 1'b0, base, led);
        if (base !== t_a[cur]) mismatch("first base", t_a[cur], base);
        press(1);
        wait_state(STORE);
        @(negedge clk);
        if (o_is_gen_mode !== (t_mode[cur] == 1)) begin
            mismatch("gen mode", t_mode[cur] == 1, o_is_gen_mode);
        end
        if (o_led !== t_led[cur]) mismatch("retry led", t_led[cur], o_led);
        do_store(t_m[cur], t_n[cur], 1'b0, base, led);
        if (base !== t_b[cur]) mismatch("second base", t_b[cur], base);
        check_counts();
        go_idle();
    endtask

    // ==============================
    // calculator core
    // ==============================
    task automatic run_execute();
        wait_state(CALC_EXECUTE);
        if (o_start_calc !== 1'b1) fault("start not raised in execute");
        if (o_op_code !== t_op[cur]) mismatch("op code", t_op[cur], o_op_code);
        if (o_op1_addr !== t_a[cur]) mismatch("op1 address", t_a[cur], o_op1_addr);
        if (o_op1_m !== t_m[cur]) mismatch("op1 rows", t_m[cur], o_op1_m);
        if (o_op1_n !== t_n[cur]) mismatch("op1 cols", t_n[cur], o_op1_n);
        // a transpose names one operand and leaves operand 2 at reset
        if (t_op[cur] == OP_TRANSPOSE) begin
            if (o_op2_addr !== '0) mismatch("op2 address", 0, o_op2_addr);
            if (o_op2_m !== '0) mismatch("op2 rows", 0, o_op2_m);
            if (o_op2_n !== '0) mismatch("op2 cols", 0, o_op2_n);
        end
        if (o_res_addr !== t_b[cur]) mismatch("result address", t_b[cur], o_res_addr);
        gap();
        @(negedge clk);
        if (o_res_addr !== t_b[cur]) mismatch("result address held", t_b[cur], o_res_addr);
        step();
        i_calc_done = 1'b1;
        step();
        i_calc_done = 1'b0;
        wait_state(WAIT_DECISION);
        if (o_start_calc !== 1'b0) fault("start still high after done");
    endtask

    // calc, badid and nohit share the operand walk
    task automatic run_calc();
        step();
        i_op_sel = op_code_t'(t_op[cur]);
        i_id_val = t_id[cur][1:0];
        enter_mode(2);
        press(0);
        wait_state(CALC_GET_DIM);
        if (o_task_mode !== 2'd1) mismatch("dim task mode", 1, o_task_mode);
        gap();
        i_dim_m      = dim_t'(t_m[cur]);
        i_dim_n      = dim_t'(t_n[cur]);
        i_dims_valid = 1'b1;
        step();
        i_dims_valid = 1'b0;
        if (t_cmd[cur] == "nohit") begin
            wait_state(ERROR);
        end else begin
            wait_state(CALC_GET_ID);
            if (o_task_mode !== 2'd2) mismatch("id task mode", 2, o_task_mode);
            gap();
            i_id_valid = 1'b1;
            step();
            i_id_valid = 1'b0;
            if (t_cmd[cur] == "badid") begin
                wait_state(ERROR);
            end else begin
                run_execute();
            end
        end
        @(negedge clk);
        if (o_led !== t_led[cur]) mismatch("led", t_led[cur], o_led);
        check_counts();
        go_idle();
    endtask

    // ==============================
    // stimulus file
    // ==============================
    task automatic read_stimulus();
        int            fd;
        int            r;
        reg [63:0]     cmd;
        reg [8*160-1:0] rest;
        fd = $fopen("test/calc_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/calc_ctrl_stimulus.txt");
        end else begin
            r = $fscanf(fd, "%s", cmd);
            while (r == 1 && n_tests < MAX_TESTS) begin
                if (cmd == "#") begin
                    r = $fgets(rest, fd);
                end else begin
                    r = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %h",
                                t_mode[n_tests], t_m[n_tests], t_n[n_tests],
                                t_id[n_tests], t_op[n_tests], t_a[n_tests],
                                t_b[n_tests], t_total[n_tests], t_types[n_tests],
                                t_led[n_tests]);
                    if (r == 10) begin
                        t_cmd[n_tests] = cmd;
                        n_tests++;
                    end else begin
                        $display("malformed stimulus line after test %0d", n_tests);
                        errors++;
                    end
                end
                r = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_all();
        int err_before;
        loaded = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (o_state !== IDLE || o_led !== 8'h00 || o_en_input !== 1'b0 ||
            o_addr_ready !== 1'b0 || o_start_calc !== 1'b0) begin
            $display("outputs not at their reset values during reset");
            errors++;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (cur = 0; cur < n_tests; cur++) begin
            err_before = errors;
            if (t_cmd[cur] == "store" || t_cmd[cur] == "errflag") begin
                run_store(t_cmd[cur] == "errflag");
            end else if (t_cmd[cur] == "retry") begin
                run_retry();
            end else if (t_cmd[cur] == "calc" || t_cmd[cur] == "badid" ||
                         t_cmd[cur] == "nohit") begin
                run_calc();
            end else begin
                fault("unknown command in stimulus file");
            end
            if (errors == err_before) begin
                $display("test %0d %0s: ok", cur, t_cmd[cur]);
            end else begin
                tests_failed++;
                $display("test %0d %0s: failed", cur, t_cmd[cur]);
            end
        end
    endtask

    // ==============================
    // main and watchdog
    // ==============================
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_btn        = 2'b00;
        i_mode_sel   = 2'd0;
        i_op_sel     = OP_TRANSPOSE;
        i_dims_valid = 1'b0;
        i_dim_m      = '0;
        i_dim_n      = '0;
        i_rx_done    = 1'b0;
        i_error_flag = 1'b0;
        i_id_val     = 2'd0;
        i_id_valid   = 1'b0;
        i_calc_done  = 1'b0;
        loaded       = 1'b0;
        n_tests      = 0;
        errors       = 0;
        tests_failed = 0;
        seed_dummy   = $urandom(32'hfd7a);
        read_stimulus();
        if (n_tests == 0) begin
            $display("no tests read from the stimulus file");
            $display("TB FAILED");
            $finish;
        end else begin
            run_all();
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     n_tests, n_tests - tests_failed, tests_failed, errors);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // budget of 400 cycles per test
    initial begin
        wait (loaded === 1'b1);
        #(n_tests * 400 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", n_tests * 400);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: source/calc_ctrl_top.sv
`timescale 1ns/1ps
`include "calc_ctrl_cfg.svh"

module calc_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 i_btn,
    input  logic [1:0]                 i_mode_sel,
    input  calc_ctrl_pkg::op_code_t    i_op_sel,
    // input subsystem
    input  logic                       i_dims_valid,
    input  calc_ctrl_pkg::dim_t        i_dim_m,
    input  calc_ctrl_pkg::dim_t        i_dim_n,
    input  logic                       i_rx_done,
    input  logic                       i_error_flag,
    input  logic [1:0]                 i_id_val,
    input  logic                       i_id_valid,
    output logic                       o_en_input,
    output logic                       o_is_gen_mode,
    output logic [1:0]                 o_task_mode,
    output logic                       o_addr_ready,
    output calc_ctrl_pkg::addr_t       o_base_addr,
    // calculator core
    input  logic                       i_calc_done,
    output logic                       o_start_calc,
    output calc_ctrl_pkg::op_code_t    o_op_code,
    output calc_ctrl_pkg::addr_t       o_op1_addr,
    output calc_ctrl_pkg::dim_t        o_op1_m,
    output calc_ctrl_pkg::dim_t        o_op1_n,
    output calc_ctrl_pkg::addr_t       o_op2_addr,
    output calc_ctrl_pkg::dim_t        o_op2_m,
    output calc_ctrl_pkg::dim_t        o_op2_n,
    output calc_ctrl_pkg::addr_t       o_res_addr,
    // status
    output logic [7:0]                 o_led,
    output calc_ctrl_pkg::ctrl_state_t o_state,
    output logic [`CC_TOTAL_W-1:0]     o_total_count,
    output logic [`CC_TYPES_W-1:0]     o_types_count
);
    import calc_ctrl_pkg::*;

    logic      s_stage;
    logic      s_id_ok;
    logic      s_need_op2;
    logic      s_hit_found;
    addr_t     s_hit_base;
    copy_cnt_t s_hit_cnt;
    dim_t      s_hit_m;
    dim_t      s_hit_n;
    dim_t      s_pred_m;
    dim_t      s_pred_n;

    mode_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_btn         (i_btn),
        .i_mode_sel    (i_mode_sel),
        .i_rx_done     (i_rx_done),
        .i_dims_valid  (i_dims_valid),
        .i_id_valid    (i_id_valid),
        .i_error_flag  (i_error_flag),
        .i_calc_done   (i_calc_done),
        .i_id_ok       (s_id_ok),
        .i_need_op2    (s_need_op2),
        .i_hit_found   (s_hit_found),
        .o_state       (o_state),
        .o_stage       (s_stage),
        .o_en_input    (o_en_input),
        .o_is_gen_mode (o_is_gen_mode),
        .o_task_mode   (o_task_mode),
        .o_start_calc  (o_start_calc),
        .o_led         (o_led)
    );

    operand_select u_opsel (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_state    (o_state),
        .i_stage    (s_stage),
        .i_op_sel   (i_op_sel),
        .i_id_val   (i_id_val),
        .i_hit_base (s_hit_base),
        .i_hit_cnt  (s_hit_cnt),
        .i_hit_m    (s_hit_m),
        .i_hit_n    (s_hit_n),
        .o_id_ok    (s_id_ok),
        .o_need_op2 (s_need_op2),
        .o_op_code  (o_op_code),
        .o_op1_addr (o_op1_addr),
        .o_op1_m    (o_op1_m),
        .o_op1_n    (o_op1_n),
        .o_op2_addr (o_op2_addr),
        .o_op2_m    (o_op2_m),
        .o_op2_n    (o_op2_n),
        .o_pred_m   (s_pred_m),
        .o_pred_n   (s_pred_n)
    );

    type_ledger u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_state       (o_state),
        .i_dims_valid  (i_dims_valid),
        .i_dim_m       (i_dim_m),
        .i_dim_n       (i_dim_n),
        .i_pred_m      (s_pred_m),
        .i_pred_n      (s_pred_n),
        .i_calc_done   (i_calc_done),
        .o_addr_ready  (o_addr_ready),
        .o_base_addr   (o_base_addr),
        .o_res_addr    (o_res_addr),
        .o_hit_found   (s_hit_found),
        .o_hit_base    (s_hit_base),
        .o_hit_cnt     (s_hit_cnt),
        .o_hit_m       (s_hit_m),
        .o_hit_n       (s_hit_n),
        .o_total_count (o_total_count),
        .o_types_count (o_types_count)
    );

endmodule

// File: source/type_ledger.sv
`timescale 1ns/1ps
`include "calc_ctrl_cfg.svh"

module type_ledger (
    input  logic                       clk,
    input  logic                       rst_n,
    input  calc_ctrl_pkg::ctrl_state_t i_state,
    input  logic                       i_dims_valid,
    input  calc_ctrl_pkg::dim_t        i_dim_m,
    input  calc_ctrl_pkg::dim_t        i_dim_n,
    input  calc_ctrl_pkg::dim_t        i_pred_m,
    input  calc_ctrl_pkg::dim_t        i_pred_n,
    input  logic                       i_calc_done,
    output logic                       o_addr_ready,
    output calc_ctrl_pkg::addr_t       o_base_addr,
    output calc_ctrl_pkg::addr_t       o_res_addr,
    output logic                       o_hit_found,
    output calc_ctrl_pkg::addr_t       o_hit_base,
    output calc_ctrl_pkg::copy_cnt_t   o_hit_cnt,
    output calc_ctrl_pkg::dim_t        o_hit_m,
    output calc_ctrl_pkg::dim_t        o_hit_n,
    output logic [`CC_TOTAL_W-1:0]     o_total_count,
    output logic [`CC_TYPES_W-1:0]     o_types_count
);
    import calc_ctrl_pkg::*;

    // shape table
    dim_t      lut_m    [`CC_MAX_TYPES];
    dim_t      lut_n    [`CC_MAX_TYPES];
    addr_t     lut_base [`CC_MAX_TYPES];
    logic      lut_slot [`CC_MAX_TYPES];
    copy_cnt_t lut_cnt  [`CC_MAX_TYPES];

    logic [`CC_TYPES_W-1:0] r_types;
    addr_t     r_free_ptr;
    logic      r_hit_found;
    type_idx_t r_hit_idx;

    dim_t      s_search_m;
    dim_t      s_search_n;
    addr_t     s_size;
    logic      s_match;
    type_idx_t s_match_idx;
    type_idx_t s_new_idx;
    addr_t     s_wr_addr;
    logic      s_update;
    logic      s_create;

    // ==============================
    // lookup
    // ==============================
    assign s_search_m = (i_state == CALC_EXECUTE) ? i_pred_m : i_dim_m;
    assign s_search_n = (i_state == CALC_EXECUTE) ? i_pred_n : i_dim_n;
    assign s_size     = addr_t'(s_search_m * s_search_n);

    always_comb begin
        s_match     = 1'b0;
        s_match_idx = '0;
        for (int i = 0; i < `CC_MAX_TYPES; i++) begin
            if (i < r_types && lut_m[i] == s_search_m && lut_n[i] == s_search_n) begin
                s_match     = 1'b1;
                s_match_idx = type_idx_t'(i);
            end
        end
    end

    // slot bit picks the ping-pong half to write next
    always_comb begin
        if (!s_match) begin
            s_wr_addr = r_free_ptr;
        end else if (lut_slot[s_match_idx]) begin
            s_wr_addr = lut_base[s_match_idx] + s_size;
        end else begin
            s_wr_addr = lut_base[s_match_idx];
        end
    end

    // ==============================
    // update
    // ==============================
    assign s_update  = (i_state == STORE && i_dims_valid && !o_addr_ready) ||
                       (i_state == CALC_EXECUTE && i_calc_done);
    assign s_new_idx = type_idx_t'(r_types);
    assign s_create  = s_update && !s_match && (r_types < `CC_MAX_TYPES);

    always_ff @(posedge clk) begin
        if (s_create) begin
            lut_m[s_new_idx]    <= s_search_m;
            lut_n[s_new_idx]    <= s_search_n;
            lut_base[s_new_idx] <= r_free_ptr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CC_MAX_TYPES; i++) begin
                lut_slot[i] <= 1'b0;
                lut_cnt[i]  <= '0;
            end
            r_types    <= '0;
            r_free_ptr <= '0;
        end else if (s_update && s_match) begin
            lut_slot[s_match_idx] <= ~lut_slot[s_match_idx];
            if (lut_cnt[s_match_idx] < `CC_MAX_COPIES) begin
                lut_cnt[s_match_idx] <= lut_cnt[s_match_idx] + 1'b1;
            end
        end else if (s_create) begin
            // room for both copies reserved up front
            lut_slot[s_new_idx] <= 1'b1;
            lut_cnt[s_new_idx]  <= 2'd1;
            r_types             <= r_types + 1'b1;
            r_free_ptr          <= r_free_ptr + (s_size << 1);
        end
    end

    // ==============================
    // store handshake and hit
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_addr_ready <= 1'b0;
            r_hit_found  <= 1'b0;
            r_hit_idx    <= '0;
        end else begin
            o_addr_ready <= (i_state == STORE) && i_dims_valid;
            // taken as the dims arrive, so the flag holds through CALC_FILTER
            if (i_state == CALC_GET_DIM && i_dims_valid) begin
                r_hit_found <= s_match && (lut_cnt[s_match_idx] != '0);
                r_hit_idx   <= s_match_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_state == STORE && i_dims_valid && !o_addr_ready) begin
            o_base_addr <= s_wr_addr;
        end
    end

    always_comb begin
        o_total_count = '0;
        for (int i = 0; i < `CC_MAX_TYPES; i++) begin
            o_total_count = o_total_count + lut_cnt[i];
        end
    end

    assign o_res_addr    = s_wr_addr;
    assign o_types_count = r_types;
    assign o_hit_found   = r_hit_found;
    assign o_hit_base    = lut_base[r_hit_idx];
    assign o_hit_cnt     = lut_cnt[r_hit_idx];
    assign o_hit_m       = lut_m[r_hit_idx];
    assign o_hit_n       = lut_n[r_hit_idx];

endmodule

// File: source/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic                       clk,
    input  logic                       rst_n,
    input  calc_ctrl_pkg::ctrl_state_t i_state,
    input  logic                       i_stage,
    input  calc_ctrl_pkg::op_code_t    i_op_sel,
    input  logic [1:0]                 i_id_val,
    input  calc_ctrl_pkg::addr_t       i_hit_base,
    input  calc_ctrl_pkg::copy_cnt_t   i_hit_cnt,
    input  calc_ctrl_pkg::dim_t        i_hit_m,
    input  calc_ctrl_pkg::dim_t        i_hit_n,
    output logic                       o_id_ok,
    output logic                       o_need_op2,
    output calc_ctrl_pkg::op_code_t    o_op_code,
    output calc_ctrl_pkg::addr_t       o_op1_addr,
    output calc_ctrl_pkg::dim_t        o_op1_m,
    output calc_ctrl_pkg::dim_t        o_op1_n,
    output calc_ctrl_pkg::addr_t       o_op2_addr,
    output calc_ctrl_pkg::dim_t        o_op2_m,
    output calc_ctrl_pkg::dim_t        o_op2_n,
    output calc_ctrl_pkg::dim_t        o_pred_m,
    output calc_ctrl_pkg::dim_t        o_pred_n
);
    import calc_ctrl_pkg::*;

    addr_t s_op_addr;
    logic  s_take;

    // ids count from 1 up to the copies held
    assign o_id_ok    = (i_id_val != 2'd0) && (i_id_val <= i_hit_cnt);
    assign o_need_op2 = (o_op_code != OP_TRANSPOSE);

    // second copy sits one matrix above the base
    assign s_op_addr = i_hit_base + addr_t'(i_hit_m * i_hit_n * (i_id_val - 2'd1));
    assign s_take    = (i_state == CALC_GET_ID) && o_id_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_op_code  <= OP_TRANSPOSE;
            o_op1_addr <= '0;
            o_op1_m    <= '0;
            o_op1_n    <= '0;
            o_op2_addr <= '0;
            o_op2_m    <= '0;
            o_op2_n    <= '0;
        end else begin
            if (i_state == CALC_SELECT_OP) begin
                o_op_code <= i_op_sel;
            end
            if (s_take && !i_stage) begin
                o_op1_addr <= s_op_addr;
                o_op1_m    <= i_hit_m;
                o_op1_n    <= i_hit_n;
            end else if (s_take) begin
                o_op2_addr <= s_op_addr;
                o_op2_m    <= i_hit_m;
                o_op2_n    <= i_hit_n;
            end
        end
    end

    // result shape for the ledger lookup
    always_comb begin
        case (o_op_code)
            OP_TRANSPOSE: begin
                o_pred_m = o_op1_n;
                o_pred_n = o_op1_m;
            end
            OP_MATMUL: begin
                o_pred_m = o_op1_m;
                o_pred_n = o_op2_n;
            end
            default: begin
                o_pred_m = o_op1_m;
                o_pred_n = o_op1_n;
            end
        endcase
    end

endmodule

// File: source/mode_sequencer.sv
`timescale 1ns/1ps
`include "calc_ctrl_cfg.svh"

module mode_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 i_btn,
    input  logic [1:0]                 i_mode_sel,
    input  logic                       i_rx_done,
    input  logic                       i_dims_valid,
    input  logic                       i_id_valid,
    input  logic                       i_error_flag,
    input  logic                       i_calc_done,
    input  logic                       i_id_ok,
    input  logic                       i_need_op2,
    input  logic                       i_hit_found,
    output calc_ctrl_pkg::ctrl_state_t o_state,
    output logic                       o_stage,
    output logic                       o_en_input,
    output logic                       o_is_gen_mode,
    output logic [1:0]                 o_task_mode,
    output logic                       o_start_calc,
    output logic [7:0]                 o_led
);
    import calc_ctrl_pkg::*;

    ctrl_state_t r_state;
    ctrl_state_t s_next;
    logic [1:0]  r_btn_d0;
    logic [1:0]  r_btn_d1;
    logic        s_confirm_edge;
    logic        s_retry_edge;
    logic [1:0]  r_mode;
    logic        r_stage;

    // ==============================
    // buttons
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_btn_d0 <= '0;
            r_btn_d1 <= '0;
        end else begin
            r_btn_d0 <= i_btn;
            r_btn_d1 <= r_btn_d0;
        end
    end

    // btn0 confirms, btn1 retries
    assign s_confirm_edge = r_btn_d0[0] & ~r_btn_d1[0];
    assign s_retry_edge   = r_btn_d0[1] & ~r_btn_d1[1];

    // ==============================
    // state machine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= IDLE;
        end else begin
            r_state <= s_next;
        end
    end

    always_comb begin
        s_next = r_state;
        case (r_state)
            IDLE: begin
                if (s_confirm_edge && i_mode_sel == 2'd2) begin
                    s_next = CALC_SELECT_OP;
                end else if (s_confirm_edge && i_mode_sel != 2'd3) begin
                    s_next = STORE;
                end
            end
            STORE: begin
                if (i_rx_done) begin
                    s_next = WAIT_DECISION;
                end
            end
            CALC_SELECT_OP: begin
                if (s_confirm_edge) begin
                    s_next = CALC_GET_DIM;
                end
            end
            CALC_GET_DIM: begin
                if (i_dims_valid) begin
                    s_next = CALC_FILTER;
                end
            end
            CALC_FILTER: begin
                s_next = i_hit_found ? CALC_GET_ID : ERROR;
            end
            CALC_GET_ID: begin
                if (i_id_valid && !i_id_ok) begin
                    s_next = ERROR;
                end else if (i_id_valid && i_need_op2 && !r_stage) begin
                    s_next = CALC_GET_DIM;
                end else if (i_id_valid) begin
                    s_next = CALC_EXECUTE;
                end
            end
            CALC_EXECUTE: begin
                if (i_calc_done) begin
                    s_next = WAIT_DECISION;
                end
            end
            WAIT_DECISION: begin
                if (s_confirm_edge) begin
                    s_next = IDLE;
                end else if (s_retry_edge) begin
                    s_next = (r_mode == 2'd2) ? CALC_SELECT_OP : STORE;
                end
            end
            ERROR: begin
                if (s_confirm_edge) begin
                    s_next = IDLE;
                end
            end
            default: s_next = IDLE;
        endcase
    end

    // remembered mode for retry, plus operand stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_mode  <= 2'd0;
            r_stage <= 1'b0;
        end else begin
            if (r_state == IDLE && s_confirm_edge && i_mode_sel != 2'd3) begin
                r_mode <= i_mode_sel;
            end
            if (r_state == CALC_SELECT_OP) begin
                r_stage <= 1'b0;
            end else if (r_state == CALC_GET_ID && i_id_valid && i_id_ok && i_need_op2) begin
                r_stage <= 1'b1;
            end
        end
    end

    // ==============================
    // outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_led <= 8'h00;
        end else begin
            case (r_state)
                IDLE:          o_led <= `CC_LED_IDLE;
                WAIT_DECISION: o_led <= `CC_LED_WAIT;
                ERROR:         o_led <= `CC_LED_ERR;
                STORE: begin
                    if (i_error_flag) begin
                        o_led <= `CC_LED_ERR;
                    end else begin
                        o_led <= o_is_gen_mode ? `CC_LED_GEN : `CC_LED_INPUT;
                    end
                end
                default:       o_led <= `CC_LED_CALC;
            endcase
        end
    end

    assign o_state       = r_state;
    assign o_stage       = r_stage;
    assign o_is_gen_mode = (r_mode == 2'd1);
    assign o_start_calc  = (r_state == CALC_EXECUTE);
    assign o_en_input    = (r_state == STORE) || (r_state == CALC_GET_DIM) ||
                           (r_state == CALC_GET_ID);
    assign o_task_mode   = (r_state == CALC_GET_DIM) ? 2'd1 :
                           (r_state == CALC_GET_ID)  ? 2'd2 : 2'd0;

endmodule

// File: source/calc_ctrl_pkg.sv
`include "calc_ctrl_cfg.svh"

package calc_ctrl_pkg;

    // ==============================
    // controller states
    // ==============================
    typedef enum logic [3:0] {
        IDLE,
        STORE,
        CALC_SELECT_OP,
        CALC_GET_DIM,
        CALC_FILTER,
        CALC_GET_ID,
        CALC_EXECUTE,
        WAIT_DECISION,
        ERROR
    } ctrl_state_t;

    // ==============================
    // widths
    // ==============================
    typedef logic [`CC_DIM_W-1:0]  dim_t;
    typedef logic [`CC_ADDR_W-1:0] addr_t;
    typedef logic [1:0]            type_idx_t;
    typedef logic [1:0]            copy_cnt_t;
    typedef logic [2:0]            op_code_t;

    // op codes the controller cares about
    localparam op_code_t OP_TRANSPOSE = 3'd0;
    localparam op_code_t OP_MATMUL    = 3'd2;

endpackage

// File: source/calc_ctrl_cfg.svh
`ifndef CALC_CTRL_CFG_SVH
`define CALC_CTRL_CFG_SVH

// ledger sizing
`define CC_MAX_TYPES  4
`define CC_MAX_COPIES 2

// datapath widths
`define CC_DIM_W   8
`define CC_ADDR_W  8

// count output widths for 4 types of up to 2 copies
`define CC_TOTAL_W 4
`define CC_TYPES_W 3

// led patterns per mode
`define CC_LED_IDLE  8'h01
`define CC_LED_INPUT 8'h02
`define CC_LED_GEN   8'h04
`define CC_LED_CALC  8'h08
`define CC_LED_WAIT  8'h80
`define CC_LED_ERR   8'hFF

`endif
